//--- all.f
+incdir+hdl
hdl/raster_pkg.sv
hdl/host_pkg.sv
hdl/raster_measure.sv
hdl/crop_keys.sv
hdl/blank_gen.sv
hdl/screen_info_regs.sv
hdl/pixel_ce_gen.sv
hdl/crop_top.sv
test/crop_sva.sv
test/crop_tb.sv

//--- hdl/blank_gen.sv
`include "crop_defines.svh"

module blank_gen import raster_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  raster_t      raster,
	input  raster_meas_t meas,
	input  crop_t        crop,
	output logic         vid_de
);

	localparam cnt_t FH_START = `FHBL_START;
	localparam cnt_t FH_GAP   = `FHBL_END_GAP;
	localparam cnt_t FV_START = `FVBL_START;
	localparam cnt_t FV_GAP   = `FVBL_END_GAP;

	logic shbl;    // Soft crop, horizontal
	logic fhbl;    // Forced, horizontal
	logic svbl;
	logic fvbl;
	logic hbl;
	logic old_hbl;

	assign hbl = shbl | fhbl | ~raster.hs_n;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			shbl    <= 1'b1;
			fhbl    <= 1'b1;
			svbl    <= 1'b1;
			fvbl    <= 1'b1;
			old_hbl <= 1'b1;
			vid_de  <= 1'b0;
		end else begin
			// Offset of 2 covers the counter and blank register stages
			if (meas.hcnt == meas.hend + crop.hbl_l - 2'd2) shbl <= 1'b0;
			if (meas.hcnt == meas.hsta + crop.hbl_r - 2'd2) shbl <= 1'b1;

			if (meas.hcnt == FH_START)           fhbl <= 1'b0;
			if (meas.hcnt == meas.hmax - FH_GAP) fhbl <= 1'b1;

			// Vertical state changes only at the start of a visible line
			old_hbl <= hbl;
			if (old_hbl && !hbl) begin
				if (meas.vcnt == meas.vend + crop.vbl_t - 1'd1) svbl <= 1'b0;
				if (meas.vcnt == meas.vsta + crop.vbl_b - 1'd1) svbl <= 1'b1;

				if (meas.vcnt == FV_START)           fvbl <= 1'b0;
				if (meas.vcnt == meas.vmax - FV_GAP) fvbl <= 1'b1;
			end

			vid_de <= ~hbl & ~(svbl | fvbl);
		end
	end

endmodule

//--- hdl/crop_defines.svh
`ifndef CROP_DEFINES_SVH
`define CROP_DEFINES_SVH

// Counter and crop width
`define CNT_W           12
`define CROP_H_STEP     4     // Left/right crop step in pixels

// Forced blanking margins
`define FHBL_START      8
`define FHBL_END_GAP    8
`define FVBL_START      1
`define FVBL_END_GAP    3

// Keyboard codes
`define KEY_BACKSPACE   8'h41
`define KEY_UP          8'h4c
`define KEY_DOWN        8'h4d
`define KEY_RIGHT       8'h4e
`define KEY_LEFT        8'h4f
`define KEY_ALT_PRESS_L 8'h64
`define KEY_ALT_PRESS_R 8'h65
`define KEY_ALT_REL_L   8'he4
`define KEY_ALT_REL_R   8'he5
`define KEY_TYPE_KBD    2'd3

// Host register word addresses
`define REG_CROP_V      2'd0
`define REG_CROP_H      2'd1
`define REG_SIZE        2'd2
`define REG_STATUS      2'd3

`endif

//--- hdl/crop_keys.sv
`include "crop_defines.svh"

module crop_keys import raster_pkg::*, host_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  kbd_evt_t   kbd,
	input  crop_load_t load,
	output crop_t      crop
);

	localparam cnt_t H_STEP = `CROP_H_STEP;

	logic old_level;
	logic alt;     // Selects bottom / right
	logic kbd_hit;

	assign kbd_hit = (old_level ^ kbd.level) && (kbd.evt_type == `KEY_TYPE_KBD);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_level <= 1'b0;
			alt       <= 1'b0;
			crop      <= '0;
		end else begin
			old_level <= kbd.level;

			if (kbd_hit) begin
				case (kbd.data)
					`KEY_BACKSPACE: crop <= '0;
					`KEY_UP: begin
						if (alt) crop.vbl_b <= crop.vbl_b + 1'd1;
						else     crop.vbl_t <= crop.vbl_t + 1'd1;
					end
					`KEY_DOWN: begin
						if (alt) crop.vbl_b <= crop.vbl_b - 1'd1;
						else     crop.vbl_t <= crop.vbl_t - 1'd1;
					end
					`KEY_LEFT: begin
						if (alt) crop.hbl_r <= crop.hbl_r + H_STEP;
						else     crop.hbl_l <= crop.hbl_l + H_STEP;
					end
					`KEY_RIGHT: begin
						if (alt) crop.hbl_r <= crop.hbl_r - H_STEP;
						else     crop.hbl_l <= crop.hbl_l - H_STEP;
					end
					`KEY_ALT_PRESS_L, `KEY_ALT_PRESS_R: alt <= 1'b1;
					`KEY_ALT_REL_L, `KEY_ALT_REL_R:     alt <= 1'b0;
					default: ;
				endcase
			end

			// Host preset overrides a key in the same cycle
			if (load.load_v) begin
				crop.vbl_t <= load.crop.vbl_t;
				crop.vbl_b <= load.crop.vbl_b;
			end
			if (load.load_h) begin
				crop.hbl_l <= load.crop.hbl_l;
				crop.hbl_r <= load.crop.hbl_r;
			end
		end
	end

endmodule

//--- hdl/crop_top.sv
module crop_top import raster_pkg::*, host_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  raster_t    raster,
	input  logic [1:0] res,
	input  logic       scandoubler,  // Static strap
	input  kbd_evt_t   kbd,
	input  wb_req_t    wb_req,
	output logic       vid_de,
	output logic       ce_pix,
	output wb_rsp_t    wb_rsp
);

	raster_meas_t meas;
	crop_t        crop;
	crop_load_t   load;

	raster_measure i_raster_measure (
		.clk_sys (clk_sys),
		.reset   (reset),
		.raster  (raster),
		.meas    (meas)
	);

	crop_keys i_crop_keys (
		.clk_sys (clk_sys),
		.reset   (reset),
		.kbd     (kbd),
		.load    (load),   // Host presets
		.crop    (crop)
	);

	blank_gen i_blank_gen (
		.clk_sys (clk_sys),
		.reset   (reset),
		.raster  (raster),
		.meas    (meas),
		.crop    (crop),
		.vid_de  (vid_de)
	);

	screen_info_regs i_screen_info_regs (
		.clk_sys (clk_sys),
		.reset   (reset),
		.res     (res),
		.meas    (meas),
		.crop    (crop),
		.raster  (raster),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp),
		.load    (load)
	);

	pixel_ce_gen i_pixel_ce_gen (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.res         (res),
		.scandoubler (scandoubler),
		.raster      (raster),
		.ce_pix      (ce_pix)
	);

endmodule

//--- hdl/host_pkg.sv
package host_pkg;

	// Wishbone classic, master to slave
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [1:0]  adr; // Word address
		logic [31:0] dat;
	} wb_req_t;

	// Wishbone classic, slave to master
	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

	// Keyboard event, new event on every toggle of level
	typedef struct packed {
		logic       level;
		logic [1:0] evt_type;
		logic [7:0] data;
	} kbd_evt_t;

endpackage

//--- hdl/pixel_ce_gen.sv
module pixel_ce_gen import raster_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic [1:0] res,
	input  logic       scandoubler,
	input  raster_t    raster,
	output logic       ce_pix
);

	logic       old_vs_n;
	logic [3:0] div;  // Phase accumulator, wraps every 16
	logic [3:0] add;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_vs_n <= 1'b1;
			div      <= '0;
			add      <= 4'd1;
			ce_pix   <= 1'b0;
		end else begin
			old_vs_n <= raster.vs_n;
			div      <= div + add;

			// Realign the pixel phase on every frame
			if (old_vs_n && !raster.vs_n) begin
				div <= '0;
				if (res[1] || !scandoubler) add <= 4'd4;
				else if (res[0])            add <= 4'd2;
				else                        add <= 4'd1;
			end

			ce_pix <= (div == 4'd8);
		end
	end

endmodule

//--- hdl/raster_measure.sv
module raster_measure import raster_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  raster_t      raster,
	output raster_meas_t meas
);

	logic old_hs_n;
	logic old_vs_n;
	logic old_hblank;
	logic old_vblank;
	logic vblank;
	logic hs_fall;
	logic hbl_rise;
	logic vbl_rise;

	// Sync counts as vertical blanking too
	assign vblank   = raster.vblank | ~raster.vs_n;
	assign hs_fall  = old_hs_n & ~raster.hs_n;
	assign hbl_rise = ~old_hblank & raster.hblank;
	assign vbl_rise = ~old_vblank & vblank;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hs_n   <= 1'b1;
			old_vs_n   <= 1'b1;
			old_hblank <= 1'b1;
			old_vblank <= 1'b1;
			meas       <= '0;
		end else begin
			old_hs_n   <= raster.hs_n;
			old_vs_n   <= raster.vs_n;
			old_hblank <= raster.hblank;
			old_vblank <= vblank;

			meas.hcnt <= meas.hcnt + 1'd1;
			if (!raster.hs_n)
				meas.hcnt <= '0; // Held during hsync

			if (old_hblank && !raster.hblank) meas.hend <= meas.hcnt;
			if (hbl_rise)                     meas.hsta <= meas.hcnt;
			if (hs_fall)                      meas.hmax <= meas.hcnt;

			// Width taken on the first active line only
			if (hbl_rise && (meas.vcnt == meas.vsta + 1'd1))
				meas.hsize <= meas.hcnt - meas.hend;

			if (hs_fall)
				meas.vcnt <= meas.vcnt + 1'd1;
			if (!raster.vs_n)
				meas.vcnt <= '0;

			if (old_vblank && !vblank) meas.vend <= meas.vcnt;
			if (vbl_rise) begin
				meas.vsta  <= meas.vcnt;
				meas.vsize <= meas.vcnt - meas.vend;
			end
			if (old_vs_n && !raster.vs_n) meas.vmax <= meas.vcnt;
		end
	end

endmodule

//--- hdl/raster_pkg.sv
`include "crop_defines.svh"

package raster_pkg;

	typedef logic [`CNT_W-1:0] cnt_t;

	// Raw raster from the video source
	typedef struct packed {
		logic hs_n;   // Active low sync
		logic vs_n;
		logic hblank; // High while blanked
		logic vblank;
	} raster_t;

	// Beam counters and captured raster geometry
	typedef struct packed {
		cnt_t hcnt;
		cnt_t vcnt;
		cnt_t hsta;  // Count at hblank rise
		cnt_t hend;  // Count at hblank fall
		cnt_t hmax;  // Line length
		cnt_t vsta;
		cnt_t vend;
		cnt_t vmax;  // Frame length in lines
		cnt_t hsize; // Active width
		cnt_t vsize; // Active height
	} raster_meas_t;

	typedef struct packed {
		cnt_t vbl_t;
		cnt_t vbl_b;
		cnt_t hbl_l;
		cnt_t hbl_r;
	} crop_t;

	// Host preset of one crop pair
	typedef struct packed {
		crop_t crop;
		logic  load_v; // Top and bottom
		logic  load_h; // Left and right
	} crop_load_t;

endpackage

//--- hdl/screen_info_regs.sv
`include "crop_defines.svh"

module screen_info_regs import raster_pkg::*, host_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic [1:0]   res,
	input  raster_meas_t meas,
	input  crop_t        crop,
	input  raster_t      raster,
	input  wb_req_t      wb_req,
	output wb_rsp_t      wb_rsp,
	output crop_load_t   load
);

	localparam int PAD = 16 - `CNT_W; // Zero bits above each 16-bit half

	logic        vblank;
	logic        old_vblank;
	cnt_t        scr_hsize;
	cnt_t        scr_vsize;
	logic [1:0]  scr_res;
	logic [6:0]  scr_flg;   // Change counter
	logic        ack;
	logic        req;
	logic        wr_hit;
	logic [31:0] rd_mux;
	logic [31:0] rd_dat;

	assign vblank = raster.vblank | ~raster.vs_n;

	// Snapshot at the end of vertical blanking
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_vblank <= 1'b1;
			scr_hsize  <= '0;
			scr_vsize  <= '0;
			scr_res    <= '0;
			scr_flg    <= '0;
		end else begin
			old_vblank <= vblank;
			if (old_vblank && !vblank) begin
				scr_hsize <= meas.hsize;
				scr_vsize <= meas.vsize;
				scr_res   <= res;
				if (scr_res != res || scr_vsize != meas.vsize || scr_hsize != meas.hsize)
					scr_flg <= scr_flg + 1'd1;
			end
		end
	end

	always_comb begin
		case (wb_req.adr)
			`REG_CROP_V: rd_mux = {{PAD{1'b0}}, crop.vbl_b, {PAD{1'b0}}, crop.vbl_t};
			`REG_CROP_H: rd_mux = {{PAD{1'b0}}, crop.hbl_r, {PAD{1'b0}}, crop.hbl_l};
			`REG_SIZE:   rd_mux = {{PAD{1'b0}}, scr_vsize, {PAD{1'b0}}, scr_hsize};
			default:     rd_mux = {17'd0, scr_flg, 6'd0, scr_res};
		endcase
	end

	assign req = wb_req.cyc & wb_req.stb & ~ack;

	// Single cycle ack, one cycle after the request
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) ack <= 1'b0;
		else       ack <= req;
	end

	always_ff @(posedge clk_sys) begin
		if (req) rd_dat <= rd_mux;
	end

	assign wb_rsp.ack = ack;
	assign wb_rsp.dat = rd_dat;

	// Writes land in the ack cycle, read-only words ignore them
	assign wr_hit = ack & wb_req.cyc & wb_req.stb & wb_req.we;

	assign load.load_v     = wr_hit && (wb_req.adr == `REG_CROP_V);
	assign load.load_h     = wr_hit && (wb_req.adr == `REG_CROP_H);
	assign load.crop.vbl_t = wb_req.dat[0 +: `CNT_W];
	assign load.crop.vbl_b = wb_req.dat[16 +: `CNT_W];
	assign load.crop.hbl_l = wb_req.dat[0 +: `CNT_W];
	assign load.crop.hbl_r = wb_req.dat[16 +: `CNT_W];

endmodule

//--- test/crop_sva.sv
module crop_sva import host_pkg::*; (
	input logic    clk_sys,
	input logic    reset,
	input wb_req_t wb_req,
	input wb_rsp_t wb_rsp
);

	int fail_count = 0; // Failed assertions so far

	// Ack is a single cycle pulse
	ack_one_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		wb_rsp.ack |=> !wb_rsp.ack)
		else begin
			$error("ack held for more than one cycle");
			fail_count++;
		end

	ack_in_request: assert property (@(posedge clk_sys) disable iff (reset)
		wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
		else begin
			$error("ack outside of a bus request");
			fail_count++;
		end

	ack_low_in_reset: assert property (@(posedge clk_sys) reset |-> !wb_rsp.ack)
		else begin
			$error("ack high during reset");
			fail_count++;
		end

endmodule

bind screen_info_regs crop_sva i_crop_sva (
	.clk_sys (clk_sys),
	.reset   (reset),
	.wb_req  (wb_req),
	.wb_rsp  (wb_rsp)
);

//--- test/crop_tb.sv
`include "crop_defines.svh"

module crop_tb import raster_pkg::*, host_pkg::*; ();

	localparam int LINE_LEN    = 64;
	localparam int FRAME_LINES = 40;
	localparam int H_ACT_W     = 32;
	localparam int V_ACT_H     = 24;
	localparam int MAX_CYCLES  = 40 * LINE_LEN * FRAME_LINES + 2000;

	typedef struct packed {
		logic [15:0] w;
		logic [15:0] h;
	} win_t;

	logic       clk_sys = 1'b0;
	logic       reset;
	raster_t    raster;
	logic [1:0] res;
	logic       scandoubler;
	kbd_evt_t   kbd;
	wb_req_t    wb_req;
	logic       vid_de;
	logic       ce_pix;
	wb_rsp_t    wb_rsp;

	int          h = LINE_LEN - 1;    // Raster position
	int          v = FRAME_LINES - 1;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          frame_no = 0;
	int          line_de = 0;
	int          max_de = 0;
	int          frame_de = 0;
	logic        win_pending = 1'b0;
	int          win_skip = 0;
	logic        alt_m = 1'b0;       // Alt state of the key model
	crop_t       model = '0;
	logic [31:0] seed = 32'h49d57b51;
	logic [7:0]  key_codes [8] = '{`KEY_UP, `KEY_DOWN, `KEY_LEFT, `KEY_RIGHT,
		`KEY_ALT_PRESS_L, `KEY_ALT_PRESS_R, `KEY_ALT_REL_L, `KEY_ALT_REL_R};

	crop_top i_crop_top (.*);

	initial forever #50 clk_sys = ~clk_sys;

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Sync at the start of each line and frame with the active area centered
	function automatic raster_t raster_at(input int hh, input int vv);
		raster_t r;
		r.hs_n   = (hh >= 4);
		r.vs_n   = (vv >= 2);
		r.hblank = (hh < 16) || (hh >= 16 + H_ACT_W);
		r.vblank = (vv < 8) || (vv >= 8 + V_ACT_H);
		return r;
	endfunction

	// Visible window for a crop setting
	function automatic win_t ref_window(input crop_t c);
		win_t r;
		r.w = H_ACT_W - c.hbl_l + c.hbl_r;
		r.h = V_ACT_H - c.vbl_t + c.vbl_b;
		return r;
	endfunction

	// Pixel enables in 64 cycles of a 16 step divider
	function automatic int ce_expected(input logic [1:0] r, input logic sd);
		int add;
		if (r[1] || !sd) add = 4;
		else if (r[0])   add = 2;
		else             add = 1;
		return 64 * add / 16;
	endfunction

	task automatic expect_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at time %0t: %s = %0h, expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic test_done(input string name, input int e0);
		$display("test %s finished with %0d errors", name, errors - e0);
	endtask

	always @(negedge clk_sys) begin
		h = (h == LINE_LEN - 1) ? 0 : h + 1;
		if (h == 0) v = (v == FRAME_LINES - 1) ? 0 : v + 1;
		raster = raster_at(h, v);
	end

	// Measures the window per frame and compares it on request
	always @(posedge clk_sys) begin
		win_t exp_win;
		if (h == 0) begin
			if (line_de > max_de) max_de = line_de;
			frame_de = frame_de + line_de;
			line_de  = 0;
			if (v == 0) begin
				frame_no++;
				if (win_pending && win_skip != 0) begin
					// A missed vertical edge can spill into the next frame
					win_skip = win_skip - 1;
				end else if (win_pending) begin
					exp_win = ref_window(model);
					expect_equal("vid_de width", max_de, exp_win.w);
					expect_equal("vid_de height", (max_de != 0) ? frame_de / max_de : 0,
						exp_win.h);
					win_pending = 1'b0;
				end
				max_de   = 0;
				frame_de = 0;
			end
		end
		line_de = line_de + vid_de;
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("ERROR: timeout, run exceeded %0d cycles", MAX_CYCLES);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	task automatic wait_frames(input int n);
		int target;
		target = frame_no + n;
		while (frame_no < target) @(negedge clk_sys);
	endtask

	task automatic wait_raster(input int vv, input int hh);
		do
			@(posedge clk_sys);
		while (v != vv || h != hh);
		@(negedge clk_sys);
	endtask

	task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
			output logic [31:0] rdat);
		int wait_cnt;
		wait_cnt = 0;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		@(negedge clk_sys);
		while (!wb_rsp.ack && wait_cnt < 16) begin
			@(negedge clk_sys);
			wait_cnt++;
		end
		if (!wb_rsp.ack) begin
			$display("ERROR: no ack from the host port at time %0t", $time);
			errors++;
		end
		rdat = wb_rsp.dat;
		@(negedge clk_sys); // Hold through the ack edge
		wb_req = '0;
	endtask

	task automatic send_key(input logic [7:0] code);
		kbd.evt_type = `KEY_TYPE_KBD;
		kbd.data     = code;
		kbd.level    = ~kbd.level; // Toggle marks a new event
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic check_crop_regs();
		logic [31:0] rd;
		bus_cycle(1'b0, `REG_CROP_V, '0, rd);
		expect_equal("REG_CROP_V", rd, {4'd0, model.vbl_b, 4'd0, model.vbl_t});
		bus_cycle(1'b0, `REG_CROP_H, '0, rd);
		expect_equal("REG_CROP_H", rd, {4'd0, model.hbl_r, 4'd0, model.hbl_l});
	endtask

	task automatic check_window();
		win_pending = 1'b1;
		win_skip    = 2;
		while (win_pending) @(negedge clk_sys);
	endtask

	// Keys that would leave the raster margins are skipped
	task automatic random_keys(input int n);
		int    sel;
		int    dv;
		int    dh;
		int    sent;
		crop_t nxt;
		sent = 0;
		while (sent < n) begin
			sel = lcg_next() >> 20 & 7;
			dv  = 0;
			dh  = 0;
			nxt = model;
			case (sel)
				0: dv = 1;
				1: dv = -1;
				2: dh = `CROP_H_STEP;
				3: dh = -`CROP_H_STEP;
				default: ;
			endcase
			if (alt_m) begin
				nxt.vbl_b = nxt.vbl_b + dv;
				nxt.hbl_r = nxt.hbl_r + dh;
			end else begin
				nxt.vbl_t = nxt.vbl_t + dv;
				nxt.hbl_l = nxt.hbl_l + dh;
			end
			if (nxt.vbl_t <= 4 && nxt.vbl_b <= 4 && nxt.hbl_l <= 8 && nxt.hbl_r <= 8) begin
				send_key(key_codes[sel]);
				model = nxt;
				if (sel >= 4) alt_m = (sel < 6);
				sent++;
			end
		end
	endtask

	initial begin
		logic [31:0] rd;
		logic [31:0] st0;
		int          e0;
		int          n;
		reset       = 1'b1;
		raster      = raster_at(h, v);
		res         = 2'd0;
		scandoubler = 1'b1;
		kbd         = '0;
		wb_req      = '0;
		e0          = errors;
		repeat (2) @(negedge clk_sys);
		expect_equal("vid_de", vid_de, 1'b0);
		expect_equal("ce_pix", ce_pix, 1'b0);
		expect_equal("wb_rsp.ack", wb_rsp.ack, 1'b0);
		repeat (2) @(negedge clk_sys);
		reset = 1'b0;
		check_crop_regs();
		bus_cycle(1'b0, `REG_STATUS, '0, rd);
		expect_equal("REG_STATUS", rd, 32'd0);
		test_done("reset", e0);

		e0 = errors;
		wait_frames(2);
		bus_cycle(1'b0, `REG_SIZE, '0, rd);
		expect_equal("REG_SIZE", rd, {16'(V_ACT_H), 16'(H_ACT_W)});
		check_window();
		test_done("size", e0);

		e0 = errors;
		repeat (3) begin
			random_keys(6);
			check_crop_regs();
			check_window();
		end
		send_key(`KEY_BACKSPACE);
		model = '0;
		check_crop_regs();
		check_window();
		test_done("keys", e0);

		e0 = errors;
		bus_cycle(1'b1, `REG_CROP_V, 32'h0003_0001, rd);
		bus_cycle(1'b1, `REG_CROP_H, 32'h0004_0008, rd);
		bus_cycle(1'b1, `REG_SIZE, 32'hffff_ffff, rd);  // Read only
		model = '{vbl_t: 12'd1, vbl_b: 12'd3, hbl_l: 12'd8, hbl_r: 12'd4};
		check_crop_regs();
		bus_cycle(1'b0, `REG_SIZE, '0, rd);
		expect_equal("REG_SIZE", rd, {16'(V_ACT_H), 16'(H_ACT_W)});
		check_window();
		test_done("host", e0);

		e0 = errors;
		bus_cycle(1'b0, `REG_STATUS, '0, st0);
		res = 2'd1;
		wait_frames(2); // Exactly one snapshot sees the change
		bus_cycle(1'b0, `REG_STATUS, '0, rd);
		expect_equal("REG_STATUS count", rd[14:8], 7'(st0[14:8] + 7'd1));
		expect_equal("REG_STATUS res", rd[1:0], 2'd1);
		for (int i = 0; i < 4; i++) begin
			res         = (i == 3) ? 2'd0 : 2'(i);
			scandoubler = (i != 3);
			wait_raster(20, 0);
			wait_raster(0, 4);
			n = 0;
			repeat (64) begin
				n = n + ce_pix;
				@(negedge clk_sys);
			end
			expect_equal("ce_pix count", n, ce_expected(res, scandoubler));
		end
		test_done("res_ce", e0);

		errors = errors + i_crop_top.i_screen_info_regs.i_crop_sva.fail_count;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
